//--- hdl/triggerPkg.sv
`default_nettype none

package triggerPkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    // Bins per frame is 2**defaultBinAddrWidth
    localparam int defaultBinAddrWidth = 6;

    // Width of the real part and of the threshold
    localparam int thresholdWidth = 16;

    //////////////////////////////////////////////////
    // Stream and RAM types
    //////////////////////////////////////////////////

    // One complex FFT bin, imaginary part on top
    typedef struct packed {
        logic signed [15:0] im;
        logic signed [15:0] re;
    } binSample_t;

    // Capture to RAM write beat
    typedef struct packed {
        logic                           en;
        logic                           bank;
        logic [defaultBinAddrWidth-1:0] addr;
        binSample_t                     data;
    } ramWrite_t;

    // Frame complete notice, bank is the one just filled
    typedef struct packed {
        logic strobe;
        logic bank;
    } frameDone_t;

    // Detector read sequence
    typedef enum logic [1:0] {
        detIdle,
        detAddr,
        detRead,
        detCompare
    } detState_t;

endpackage

`default_nettype wire

//--- hdl/streamCapture.sv
`timescale 1ns/1ns
`default_nettype none

module streamCapture #(
    parameter int binAddrWidth = triggerPkg::defaultBinAddrWidth
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  triggerPkg::binSample_t tData,
    input  logic                   tValid,
    output logic                   tReady,
    output triggerPkg::ramWrite_t  ramWr,
    output triggerPkg::frameDone_t frameDone
);

    // Write side state
    logic [binAddrWidth-1:0] wrAddr;
    logic                    wrBank;

    // Beat handshake
    logic accept;
    logic lastBeat;

    //////////////////////////////////////////////////
    // Slave handshake
    //////////////////////////////////////////////////

    // Ready is a plain level, low only in reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tReady <= 1'b0;
        end else begin
            tReady <= 1'b1;
        end
    end

    assign accept   = tValid && tReady;
    // Final bin of the frame
    assign lastBeat = accept && (wrAddr == {binAddrWidth{1'b1}});

    //////////////////////////////////////////////////
    // Address counter and bank toggle
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrAddr          <= '0;
            wrBank          <= 1'b0;
            frameDone.strobe <= 1'b0;
            frameDone.bank   <= 1'b0;
        end else begin
            // Single cycle strobe by default
            frameDone.strobe <= 1'b0;
            // Gaps in tValid just hold the count
            if (accept) begin
                wrAddr <= wrAddr + 1'b1;
            end
            if (lastBeat) begin
                // Tag notice with the bank just filled
                frameDone.strobe <= 1'b1;
                frameDone.bank   <= wrBank;
                wrBank           <= ~wrBank;
            end
        end
    end

    // RAM write goes out the same cycle as the beat
    always_comb begin
        ramWr                        = '0;
        ramWr.en                     = accept;
        ramWr.bank                   = wrBank;
        ramWr.addr[binAddrWidth-1:0] = wrAddr;
        ramWr.data                   = tData;
    end

endmodule

`default_nettype wire

//--- hdl/binRam.sv
`timescale 1ns/1ns
`default_nettype none

module binRam #(
    parameter int binAddrWidth = triggerPkg::defaultBinAddrWidth
) (
    input  logic                    clk,
    input  triggerPkg::ramWrite_t   wr,
    input  logic                    rdEn,
    input  logic                    rdBank,
    input  logic [binAddrWidth-1:0] rdAddr,
    output triggerPkg::binSample_t  rdData
);

    import triggerPkg::*;

    // Two banks back to back, bank bit on top
    localparam int depth = 2 ** (binAddrWidth + 1);

    binSample_t mem [depth];

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[{wr.bank, wr.addr[binAddrWidth-1:0]}] <= wr.data;
        end
    end

    //////////////////////////////////////////////////
    // Registered read port
    //////////////////////////////////////////////////

    // Reader always sits on the opposite bank
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[{rdBank, rdAddr}];
        end
    end

endmodule

`default_nettype wire

//--- hdl/binDetector.sv
`timescale 1ns/1ns
`default_nettype none

module binDetector #(
    parameter int binAddrWidth = triggerPkg::defaultBinAddrWidth
) (
    input  logic                                clk,
    input  logic                                arstN,
    input  triggerPkg::frameDone_t              frameDone,
    input  logic [triggerPkg::thresholdWidth-1:0] threshold,
    input  logic [binAddrWidth-1:0]             frequency,
    input  logic [1:0]                          offset,
    output logic                                rdEn,
    output logic                                rdBank,
    output logic [binAddrWidth-1:0]             rdAddr,
    input  triggerPkg::binSample_t              rdData,
    output logic                                trigger
);

    import triggerPkg::*;

    detState_t state;

    // Threshold held for the whole read sequence
    logic [thresholdWidth-1:0] thrLatched;
    logic                      start;
    logic                      binHit;

    assign start = (state == detIdle) && frameDone.strobe;

    //////////////////////////////////////////////////
    // Read sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= detIdle;
            trigger <= 1'b0;
        end else begin
            case (state)
                // Wait for a finished frame
                detIdle: begin
                    if (frameDone.strobe) begin
                        state <= detAddr;
                    end
                end
                // Address on the RAM, read fires at the next edge
                detAddr: state <= detRead;
                // Bin is on rdData, result lands on entry to compare
                detRead: begin
                    state   <= detCompare;
                    trigger <= binHit;
                end
                detCompare: state <= detIdle;
                default: state <= detIdle;
            endcase
        end
    end

    // Selected bin and threshold, taken with the strobe
    always_ff @(posedge clk) begin
        if (start) begin
            thrLatched <= threshold;
            rdBank     <= frameDone.bank;
            // Wraps modulo the frame size
            rdAddr     <= frequency + binAddrWidth'(offset);
        end
    end

    assign rdEn = (state == detAddr);

    //////////////////////////////////////////////////
    // Threshold compare
    //////////////////////////////////////////////////

    // Negative real part never triggers
    always_comb begin
        binHit = !rdData.re[thresholdWidth-1] && (unsigned'(rdData.re) > thrLatched);
    end

endmodule

`default_nettype wire

//--- hdl/triggerDetect.sv
`timescale 1ns/1ns
`default_nettype none

module triggerDetect #(
    parameter int binAddrWidth = triggerPkg::defaultBinAddrWidth
) (
    input  logic                                clk,
    input  logic                                arstN,
    input  triggerPkg::binSample_t              tData,
    input  logic                                tValid,
    input  logic [triggerPkg::thresholdWidth-1:0] threshold,
    input  logic [binAddrWidth-1:0]             frequency,
    input  logic [1:0]                          offset,
    output logic                                tReady,
    output logic                                trigger,
    output logic                                frameReady
);

    import triggerPkg::*;

    // Stage to stage links
    ramWrite_t               ramWr;
    frameDone_t              frameDone;
    logic                    rdEn;
    logic                    rdBank;
    logic [binAddrWidth-1:0] rdAddr;
    binSample_t              rdData;

    // Capture of the incoming stream
    streamCapture #(.binAddrWidth(binAddrWidth)) capture (
        .clk       (clk),
        .arstN     (arstN),
        .tData     (tData),
        .tValid    (tValid),
        .tReady    (tReady),
        .ramWr     (ramWr),
        .frameDone (frameDone)
    );

    // Frame store, ping pong banks
    binRam #(.binAddrWidth(binAddrWidth)) ram (
        .clk    (clk),
        .wr     (ramWr),
        .rdEn   (rdEn),
        .rdBank (rdBank),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    // Bin pick and compare
    binDetector #(.binAddrWidth(binAddrWidth)) detector (
        .clk       (clk),
        .arstN     (arstN),
        .frameDone (frameDone),
        .threshold (threshold),
        .frequency (frequency),
        .offset    (offset),
        .rdEn      (rdEn),
        .rdBank    (rdBank),
        .rdAddr    (rdAddr),
        .rdData    (rdData),
        .trigger   (trigger)
    );

    // Frame pulse straight from capture
    assign frameReady = frameDone.strobe;

endmodule

`default_nettype wire

//--- testbench/triggerDetect_props.sv
`timescale 1ns/1ns
`default_nettype none

module triggerDetect_props (
    input logic clk,
    input logic arstN,
    input logic tValid,
    input logic tReady,
    input logic frameReady,
    input logic trigger
);

    // frameReady rise history, three edges deep
    logic       frameReadyQ;
    logic [2:0] riseAge;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            frameReadyQ <= 1'b0;
            riseAge     <= '0;
        end else begin
            frameReadyQ <= frameReady;
            riseAge     <= {riseAge[1:0], frameReady && !frameReadyQ};
        end
    end

    //////////////////////////////////////////////////
    // Handshake and pulse timing
    //////////////////////////////////////////////////

    readyLowInReset: assert property (@(posedge clk) !arstN |-> !tReady)
        else $error("tReady high while reset is asserted");

    singleCyclePulse: assert property (@(posedge clk) disable iff (!arstN)
        frameReady |=> !frameReady)
        else $error("frameReady high for two cycles");

    // Only update slot is three edges after the rise
    triggerUpdateSlot: assert property (@(posedge clk) disable iff (!arstN)
        (trigger != $past(trigger)) |-> riseAge[2])
        else $error("trigger changed outside its update slot");

    pulseAfterBeat: assert property (@(posedge clk) disable iff (!arstN)
        $rose(frameReady) |-> $past(tValid && tReady))
        else $error("frameReady rose without an accepted beat");

endmodule

bind triggerDetect triggerDetect_props props (
    .clk        (clk),
    .arstN      (arstN),
    .tValid     (tValid),
    .tReady     (tReady),
    .frameReady (frameReady),
    .trigger    (trigger)
);

`default_nettype wire

//--- testbench/triggerDetect_tb.sv
`timescale 1ns/1ns
`default_nettype none

module triggerDetect_tb;

    import triggerPkg::*;

    localparam int          clkPeriod    = 40;
    localparam int          numFrames    = 40;
    localparam int          addrWidth    = 6;
    localparam int          binsPerFrame = 2 ** addrWidth;
    localparam logic [15:0] lfsrSeed     = 16'd22;
    // Every beat may take up to four cycles
    localparam int          watchdogNs   = numFrames * binsPerFrame * 4 * clkPeriod;

    // Forced values on the selected bin
    localparam int modeRandom   = 0;
    localparam int modeEqual    = 1;
    localparam int modeAbove    = 2;
    localparam int modeNegative = 3;

    // DUT ports
    logic                 clk;
    logic                 arstN;
    binSample_t           tData;
    logic                 tValid;
    logic                 tReady;
    logic [15:0]          threshold;
    logic [addrWidth-1:0] frequency;
    logic [1:0]           offset;
    logic                 trigger;
    logic                 frameReady;

    logic [15:0] lfsrState;

    // Controls of the frame now being sent
    logic [15:0]          sendThr;
    logic [addrWidth-1:0] sendFreq;
    logic [1:0]           sendOff;
    int                   sendMode;
    int                   sendIdx;
    int                   sendFrame;

    // Reference model state
    binSample_t shadow [binsPerFrame];
    int         rxIdx;
    int         framesDone;
    logic       lastValid;
    logic       lastReady;
    binSample_t lastData;
    logic       modelTrig;
    logic       pendingTrig;
    int         trigCountdown;
    logic       applyPending;

    triggerDetect #(.binAddrWidth(addrWidth)) uut (
        .clk        (clk),
        .arstN      (arstN),
        .tData      (tData),
        .tValid     (tValid),
        .threshold  (threshold),
        .frequency  (frequency),
        .offset     (offset),
        .tReady     (tReady),
        .trigger    (trigger),
        .frameReady (frameReady)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Random source
    //////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value     = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    // Threshold kept below 2**14 so threshold + 1 stays positive
    task automatic pickFrameControls(input int frameNo);
        sendThr  = 16'(takeBits(14));
        sendFreq = addrWidth'(takeBits(addrWidth));
        sendOff  = 2'(takeBits(2));
        sendMode = modeRandom;
        case (frameNo)
            0: sendMode = modeEqual;
            1: sendMode = modeAbove;
            2: sendMode = modeNegative;
            // Bin 0 during back to back frames
            3: begin
                sendFreq = '0;
                sendOff  = '0;
                sendMode = modeAbove;
            end
            // Negative first beat would spoil a read of the wrong bank
            4: begin
                sendFreq = '0;
                sendOff  = '0;
                sendMode = modeNegative;
            end
            // Wrap past the last bin
            5: begin
                sendFreq = addrWidth'(binsPerFrame - 2);
                sendOff  = 2'd3;
            end
            6: begin
                sendFreq = addrWidth'(binsPerFrame - 1);
                sendOff  = 2'd2;
                sendMode = modeAbove;
            end
            default: ;
        endcase
    endtask

    //////////////////////////////////////////////////
    // Model and checks
    //////////////////////////////////////////////////

    // Non-negative real part strictly above threshold
    function automatic logic expectedTrigger();
        int binIdx;
        int reVal;
        binIdx = (int'(frequency) + int'(offset)) % binsPerFrame;
        reVal  = int'(shadow[binIdx].re);
        return (reVal >= 0) && (reVal > int'(threshold));
    endfunction

    task automatic checkValue(input string sigName, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t ns",
                     sigName, actual, expected, $time);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", sigName);
        end
    endtask

    // Beat of the last rising edge enters the shadow before the compares
    task automatic stepModel();
        logic expFrame;
        expFrame = 1'b0;
        if (lastValid && lastReady) begin
            shadow[rxIdx] = lastData;
            if (rxIdx == binsPerFrame - 1) begin
                expFrame = 1'b1;
                rxIdx    = 0;
            end else begin
                rxIdx++;
            end
        end
        checkValue("tReady", 32'(tReady), 32'd1);
        checkValue("frameReady", 32'(frameReady), 32'(expFrame));
        // New result lands three edges after the pulse
        if (trigCountdown > 0) begin
            trigCountdown--;
            if (trigCountdown == 0) begin
                modelTrig = pendingTrig;
            end
        end
        checkValue("trigger", 32'(trigger), 32'(modelTrig));
        if (expFrame) begin
            pendingTrig   = expectedTrigger();
            trigCountdown = 3;
            framesDone++;
            applyPending  = 1'b1;
        end else if (applyPending) begin
            // Detector took the old controls one edge ago
            threshold    = sendThr;
            frequency    = sendFreq;
            offset       = sendOff;
            applyPending = 1'b0;
        end
    endtask

    task automatic driveBeat();
        binSample_t beat;
        logic       valid;
        int         selIdx;
        beat      = '0;
        valid     = 1'b0;
        lastReady = tReady;
        if (sendFrame < numFrames && tReady) begin
            // tValid held high on frames 3 to 5
            if (sendFrame >= 3 && sendFrame <= 5) begin
                valid = 1'b1;
            end else begin
                valid = (takeBits(2) != 32'd0);
            end
            beat = binSample_t'(takeBits(32));
            if (valid) begin
                selIdx = (int'(sendFreq) + int'(sendOff)) % binsPerFrame;
                if (sendIdx == selIdx) begin
                    case (sendMode)
                        modeEqual:    beat.re = $signed(sendThr);
                        modeAbove:    beat.re = $signed(sendThr + 16'd1);
                        modeNegative: beat.re = 16'sh8001;
                        default: ;
                    endcase
                end
                sendIdx++;
                if (sendIdx == binsPerFrame) begin
                    sendIdx = 0;
                    sendFrame++;
                    pickFrameControls(sendFrame);
                end
            end
        end
        tValid    = valid;
        tData     = beat;
        lastValid = valid;
        lastData  = beat;
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        lfsrState     = lfsrSeed;
        arstN         = 1'b0;
        tValid        = 1'b0;
        tData         = '0;
        sendIdx       = 0;
        sendFrame     = 0;
        rxIdx         = 0;
        framesDone    = 0;
        lastValid     = 1'b0;
        lastReady     = 1'b0;
        lastData      = '0;
        modelTrig     = 1'b0;
        pendingTrig   = 1'b0;
        trigCountdown = 0;
        applyPending  = 1'b0;
        pickFrameControls(0);
        threshold = sendThr;
        frequency = sendFreq;
        offset    = sendOff;
        // Outputs quiet in reset
        repeat (3) begin
            @(negedge clk);
            checkValue("tReady", 32'(tReady), 32'd0);
            checkValue("trigger", 32'(trigger), 32'd0);
            checkValue("frameReady", 32'(frameReady), 32'd0);
        end
        arstN = 1'b1;
        // Run until the last frame's trigger has been checked
        while (framesDone < numFrames || trigCountdown > 0) begin
            @(negedge clk);
            stepModel();
            driveBeat();
        end
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("Timeout: the frames did not finish in %0d ns", watchdogNs);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- build.f
hdl/triggerPkg.sv
hdl/streamCapture.sv
hdl/binRam.sv
hdl/binDetector.sv
hdl/triggerDetect.sv
testbench/triggerDetect_props.sv
testbench/triggerDetect_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := triggerDetect_tb
FILELIST   := build.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := RESULT: PASS
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

# Pass or fail comes from the log, not from the exit status
sim: $(BUILD_DIR)/$(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
